//--- memPkg.sv
package memPkg;

    // request address width, wider than the RAM so addresses wrap
    localparam int addrWidth = 17;

    // number of bytes moved by one access
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize_e;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic        done;
        logic [31:0] inst;
    } fetchRsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        accessSize_e          size;
        logic [addrWidth-1:0] addr;
        logic [31:0]          wdata;
    } dataReq_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } dataRsp_t;

    // one byte access on the RAM side
    typedef struct packed {
        logic                 en;
        logic                 write;
        logic [addrWidth-1:0] addr;
        logic [7:0]           wdata;
    } ramReq_t;

endpackage

//--- beatCounter.sv
module beatCounter (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                beatEn,
    input  memPkg::accessSize_e size,
    output logic [2:0]          beat,
    output logic                lastIssue
);

    logic [2:0] byteCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= 3'd0;
        end else if (start) begin
            beat <= 3'd0;
        end else if (beatEn) begin
            beat <= beat + 3'd1;
        end
    end

    // bytes per access
    always_comb begin
        case (size)
            memPkg::sizeByte: byteCount = 3'd1;
            memPkg::sizeHalf: byteCount = 3'd2;
            default:          byteCount = 3'd4;
        endcase
    end

    assign lastIssue = (beat + 3'd1) == byteCount;

endmodule

//--- memArbiter.sv
module memArbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold,
    input  memPkg::fetchReq_t   fetchReq,
    input  memPkg::dataReq_t    dataReq,
    input  logic [2:0]          beat,
    input  logic                lastIssue,
    input  logic [7:0]          wrByte,
    output logic                start,
    output logic                beatEn,
    output memPkg::accessSize_e size,
    output logic                capture,
    output memPkg::ramReq_t     ramReq,
    output logic                fetchDone,
    output logic                dataDone
);

    typedef enum logic [2:0] {
        idle,
        issueFetch,
        issueLoad,
        issueStore,
        drain,
        respond
    } state_e;

    state_e                       state;
    state_e                       stateNext;
    logic                         servedFetch;
    logic [memPkg::addrWidth-1:0] addrQ;
    memPkg::accessSize_e          sizeQ;
    logic                         captureQ;
    logic [memPkg::addrWidth-1:0] baseAddr;
    logic                         issuing;

    // data port has priority over fetch
    always_comb begin
        if (state == idle) begin
            baseAddr = dataReq.valid ? dataReq.addr : fetchReq.addr;
            size     = dataReq.valid ? dataReq.size : memPkg::sizeWord;
            issuing  = dataReq.valid || fetchReq.valid;
        end else begin
            baseAddr = addrQ;
            size     = sizeQ;
            issuing  = (state == issueFetch) || (state == issueLoad) ||
                       (state == issueStore);
        end
    end

    always_comb begin
        ramReq.en    = issuing;
        ramReq.write = (state == idle) ? (dataReq.valid && dataReq.write)
                                       : (state == issueStore);
        ramReq.addr  = baseAddr + memPkg::addrWidth'(beat);
        ramReq.wdata = wrByte;
    end

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (dataReq.valid) begin
                    if (lastIssue) begin
                        stateNext = dataReq.write ? respond : drain;
                    end else begin
                        stateNext = dataReq.write ? issueStore : issueLoad;
                    end
                end else if (fetchReq.valid) begin
                    stateNext = issueFetch;
                end
            end
            issueFetch, issueLoad: begin
                if (lastIssue) begin
                    stateNext = drain;
                end
            end
            issueStore: begin
                if (lastIssue) begin
                    stateNext = respond;
                end
            end
            // final read byte lands this cycle
            drain:   stateNext = respond;
            respond: stateNext = idle;
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            servedFetch <= 1'b0;
            captureQ    <= 1'b0;
        end else if (!hold) begin
            state    <= stateNext;
            captureQ <= ramReq.en && !ramReq.write;
            if (state == idle && issuing) begin
                servedFetch <= !dataReq.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && state == idle && issuing) begin
            addrQ <= baseAddr;
            sizeQ <= size;
        end
    end

    assign beatEn    = ramReq.en && !hold;
    assign start     = (state == respond) && !hold;
    assign capture   = captureQ;
    assign fetchDone = start && servedFetch;
    assign dataDone  = start && !servedFetch;

endmodule

//--- loadAssembler.sv
module loadAssembler (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold,
    input  logic                start,
    input  logic                capture,
    input  memPkg::accessSize_e size,
    input  logic [7:0]          rdByte,
    output logic [31:0]         word
);

    logic [31:0] shiftReg;

    // bytes enter at the top and move down, so the first byte ends lowest
    always_ff @(posedge clk) begin
        if (rst) begin
            shiftReg <= 32'd0;
        end else if (!hold) begin
            if (start) begin
                shiftReg <= 32'd0;
            end else if (capture) begin
                shiftReg <= {rdByte, shiftReg[31:8]};
            end
        end
    end

    // align to lane 0 and zero the unused upper lanes
    always_comb begin
        case (size)
            memPkg::sizeByte: word = {24'd0, shiftReg[31:24]};
            memPkg::sizeHalf: word = {16'd0, shiftReg[31:16]};
            default:          word = shiftReg;
        endcase
    end

endmodule

//--- storeSerializer.sv
module storeSerializer (
    input  logic [31:0] wdata,
    input  logic [2:0]  beat,
    output logic [7:0]  wrByte
);

    // beat k drives byte lane k
    always_comb begin
        case (beat[1:0])
            2'd0:    wrByte = wdata[7:0];
            2'd1:    wrByte = wdata[15:8];
            2'd2:    wrByte = wdata[23:16];
            default: wrByte = wdata[31:24];
        endcase
    end

endmodule

//--- byteRam.sv
module byteRam #(
    parameter int ramAddrBits = 10
) (
    input  logic            clk,
    input  logic            hold,
    input  memPkg::ramReq_t ramReq,
    output logic [7:0]      rdByte
);

    logic [7:0]             mem [2**ramAddrBits];
    logic [ramAddrBits-1:0] index;

    initial begin
        for (int i = 0; i < 2**ramAddrBits; i++) begin
            mem[i] = 8'd0;
        end
    end

    // upper address bits ignored
    assign index = ramReq.addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (!hold && ramReq.en) begin
            if (ramReq.write) begin
                mem[index] <= ramReq.wdata;
            end else begin
                rdByte <= mem[index];
            end
        end
    end

endmodule

//--- memCtrl.sv
module memCtrl #(
    parameter int ramAddrBits = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    input  memPkg::fetchReq_t fetchReq,
    output memPkg::fetchRsp_t fetchRsp,
    input  memPkg::dataReq_t  dataReq,
    output memPkg::dataRsp_t  dataRsp
);

    logic                start;
    logic                beatEn;
    memPkg::accessSize_e size;
    logic                capture;
    memPkg::ramReq_t     ramReq;
    logic [2:0]          beat;
    logic                lastIssue;
    logic [7:0]          wrByte;
    logic [7:0]          rdByte;
    logic [31:0]         word;
    logic                fetchDone;
    logic                dataDone;

    memArbiter u_memArbiter (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .beat      (beat),
        .lastIssue (lastIssue),
        .wrByte    (wrByte),
        .start     (start),
        .beatEn    (beatEn),
        .size      (size),
        .capture   (capture),
        .ramReq    (ramReq),
        .fetchDone (fetchDone),
        .dataDone  (dataDone)
    );

    beatCounter u_beatCounter (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .beatEn    (beatEn),
        .size      (size),
        .beat      (beat),
        .lastIssue (lastIssue)
    );

    loadAssembler u_loadAssembler (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .start   (start),
        .capture (capture),
        .size    (size),
        .rdByte  (rdByte),
        .word    (word)
    );

    // store data is held stable by the requester until done
    storeSerializer u_storeSerializer (
        .wdata  (dataReq.wdata),
        .beat   (beat),
        .wrByte (wrByte)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) u_byteRam (
        .clk    (clk),
        .hold   (hold),
        .ramReq (ramReq),
        .rdByte (rdByte)
    );

    assign fetchRsp.done  = fetchDone;
    assign fetchRsp.inst  = fetchDone ? word : 32'd0;
    assign dataRsp.done   = dataDone;
    assign dataRsp.rdata  = dataDone ? word : 32'd0;

endmodule

//--- memCtrlTb.sv
module memCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ramAddrBits = 10;
    localparam int addrWidth   = memPkg::addrWidth;
    localparam int cycleLimit  = 2000;

    logic              clk = 1'b0;
    logic              rst;
    logic              hold;
    memPkg::fetchReq_t fetchReq;
    memPkg::fetchRsp_t fetchRsp;
    memPkg::dataReq_t  dataReq;
    memPkg::dataRsp_t  dataRsp;
    logic [7:0]        refMem [2**ramAddrBits];
    logic [31:0]       rngState = 32'd45;
    int                cycleCount = 0;

    memCtrl #(
        .ramAddrBits (ramAddrBits)
    ) u_memCtrl (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Test failed");
            $fatal(1, "timeout: simulation exceeded 2000 cycles");
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // reference memory wraps like the RAM, little-endian, zero-extended
    function automatic logic [31:0] refRead(input logic [addrWidth-1:0] addr, input int nBytes);
        logic [31:0] value;
        value = 32'd0;
        for (int k = 0; k < nBytes; k++) begin
            value[8*k +: 8] = refMem[addr[ramAddrBits-1:0] + ramAddrBits'(k)];
        end
        return value;
    endfunction

    function automatic void refWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                                     input int nBytes);
        for (int k = 0; k < nBytes; k++) begin
            refMem[addr[ramAddrBits-1:0] + ramAddrBits'(k)] = data[8*k +: 8];
        end
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("FAIL %0t: %s", $time, msg);
            $display("Test failed");
            $fatal(1, "stopping at the first failed check");
        end
    endtask

    // one request until its done, hold high in cycles holdAt .. holdAt+holdLen-1
    task automatic transact(input logic isFetch, input logic write,
                            input memPkg::accessSize_e size, input logic [addrWidth-1:0] addr,
                            input logic [31:0] wdata, input int holdAt, input int holdLen);
        int          nBytes;
        int          expected;
        int          latency;
        logic        done;
        logic [31:0] result;
        nBytes   = (size == memPkg::sizeByte) ? 1 : (size == memPkg::sizeHalf) ? 2 : 4;
        expected = nBytes + holdLen + (write ? 0 : 1);
        latency  = 0;
        done     = 1'b0;
        @(negedge clk);
        fetchReq = '{valid: isFetch, addr: addr};
        dataReq  = '{valid: !isFetch, write: write, size: size, addr: addr, wdata: wdata};
        while (!done) begin
            hold = (latency >= holdAt) && (latency < holdAt + holdLen);
            #1;
            done   = isFetch ? fetchRsp.done : dataRsp.done;
            result = isFetch ? fetchRsp.inst : dataRsp.rdata;
            if (!done) begin
                @(negedge clk);
                latency++;
            end
        end
        check(latency == expected,
              $sformatf("done after %0d cycles, expected %0d", latency, expected));
        if (write) begin
            refWrite(addr, wdata, nBytes);
        end else begin
            check(result == refRead(addr, nBytes),
                  $sformatf("read at %h returned %h, expected %h",
                            addr, result, refRead(addr, nBytes)));
        end
        @(negedge clk);
        fetchReq.valid = 1'b0;
        dataReq.valid  = 1'b0;
        hold           = 1'b0;
        #1;
        check(!fetchRsp.done && !dataRsp.done, "done stayed high for a second cycle");
    endtask

    task automatic wordStoreLoad();
        logic [addrWidth-1:0] addr;
        addr = addrWidth'(nextRandom());
        #1;
        check(!fetchRsp.done && !dataRsp.done, "a done output is high after reset");
        transact(1'b0, 1'b1, memPkg::sizeWord, addr, nextRandom(), 0, 0);
        transact(1'b0, 1'b0, memPkg::sizeWord, addr, 32'd0, 0, 0);
    endtask

    task automatic laneLoads();
        logic [addrWidth-1:0] addr;
        addr = addrWidth'(nextRandom());
        transact(1'b0, 1'b1, memPkg::sizeWord, addr, nextRandom(), 0, 0);
        transact(1'b0, 1'b0, memPkg::sizeByte, addr + addrWidth'(1), 32'd0, 0, 0);
        transact(1'b0, 1'b0, memPkg::sizeHalf, addr + addrWidth'(2), 32'd0, 0, 0);
    endtask

    task automatic partialStores();
        logic [addrWidth-1:0] addr;
        memPkg::accessSize_e  size;
        for (int i = 0; i < 20; i++) begin
            addr = addrWidth'(nextRandom());
            size = (i % 2 == 1) ? memPkg::sizeHalf : memPkg::sizeByte;
            // known neighbours on both sides of the narrow store
            transact(1'b0, 1'b1, memPkg::sizeWord, addr - addrWidth'(1), nextRandom(), 0, 0);
            transact(1'b0, 1'b1, size, addr, nextRandom(), 0, 0);
            transact(1'b0, 1'b0, memPkg::sizeWord, addr - addrWidth'(1), 32'd0, 0, 0);
        end
    endtask

    task automatic fetches();
        logic [addrWidth-1:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = addrWidth'(nextRandom());
            transact(1'b0, 1'b1, memPkg::sizeWord, addr, nextRandom(), 0, 0);
            transact(1'b1, 1'b0, memPkg::sizeWord, addr, 32'd0, 0, 0);
            transact(1'b1, 1'b0, memPkg::sizeWord, addr + addrWidth'(2), 32'd0, 0, 0);
        end
    endtask

    task automatic sameCycleRequests();
        logic [addrWidth-1:0] addr;
        logic [31:0]          data;
        logic [31:0]          inst;
        int                   cycle;
        int                   dataAt;
        int                   fetchAt;
        addr    = addrWidth'(nextRandom());
        data    = nextRandom();
        cycle   = 0;
        dataAt  = -1;
        fetchAt = -1;
        @(negedge clk);
        dataReq  = '{valid: 1'b1, write: 1'b1, size: memPkg::sizeWord, addr: addr, wdata: data};
        fetchReq = '{valid: 1'b1, addr: addr};
        while (fetchAt < 0) begin
            #1;
            if (dataRsp.done) begin
                dataAt = cycle;
            end
            if (fetchRsp.done) begin
                fetchAt = cycle;
                inst    = fetchRsp.inst;
            end
            @(negedge clk);
            cycle++;
            if (dataAt >= 0) begin
                dataReq.valid = 1'b0;
            end
        end
        fetchReq.valid = 1'b0;
        refWrite(addr, data, 4);
        check(dataAt == 4, $sformatf("store done at cycle %0d, expected 4", dataAt));
        // fetch is accepted the cycle after the store's done
        check(fetchAt == dataAt + 6, $sformatf("fetch done at cycle %0d", fetchAt));
        check(inst == refRead(addr, 4),
              $sformatf("fetch returned %h, expected %h", inst, refRead(addr, 4)));
    endtask

    task automatic holdDelays();
        logic [addrWidth-1:0] addr;
        addr = addrWidth'(nextRandom());
        transact(1'b0, 1'b1, memPkg::sizeWord, addr, nextRandom(), 0, 0);
        transact(1'b0, 1'b0, memPkg::sizeWord, addr, 32'd0, 2, 3);
        transact(1'b1, 1'b0, memPkg::sizeWord, addr, 32'd0, 1, 2);
        transact(1'b0, 1'b0, memPkg::sizeHalf, addr, 32'd0, 1, 1);
    endtask

    initial begin
        rst      = 1'b1;
        hold     = 1'b0;
        fetchReq = '0;
        dataReq  = '0;
        refMem   = '{default: 8'd0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wordStoreLoad();
        laneLoads();
        partialStores();
        fetches();
        sameCycleRequests();
        holdDelays();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- memCtrl.f
memPkg.sv
beatCounter.sv
memArbiter.sv
loadAssembler.sv
storeSerializer.sv
byteRam.sv
memCtrl.sv
memCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module memCtrlTb \
    -f memCtrl.f \
    -o memCtrlSim

./obj_dir/memCtrlSim
